// File: build.f
src/split_join_pkg.sv
src/axis_pkg.sv
src/hdr_splitter.sv
src/pyld_fifo.sv
src/hdr_joiner.sv
src/split_join_top.sv
verification/split_join_properties.sv
verification/split_join_tb.sv

// File: verification/split_join_tb.sv
// ----------------------------
// split/join testbench.
// random packets, a header loopback that
// inverts the data, and a reference model
// of the header and joined packet streams.
// ----------------------------

`timescale 1ns/1ps

module split_join_tb
   import axis_pkg::*;
   import split_join_pkg::*;
();

   localparam logic [31:0] SEED        = 32'he6af_eb1e;
   localparam int          MAX_LEN     = 12;
   localparam int          CYCLE_LIMIT = 20000;

   logic       axi4s_in;
   logic       rst;
   hdr_len_t   hdr_length;
   logic       sop_mismatch_clr;
   logic       sop_mismatch;
   axis_beat_t pkt_in_beat;
   logic       pkt_in_valid;
   logic       pkt_in_ready;
   axis_beat_t hdr_out_beat;
   logic       hdr_out_valid;
   logic       hdr_out_ready;
   axis_beat_t hdr_in_beat;
   logic       hdr_in_valid;
   logic       hdr_in_ready;
   axis_beat_t pkt_out_beat;
   logic       pkt_out_valid;
   logic       pkt_out_ready;

   // stimulus, the loopback queue and the two expected streams.
   axis_beat_t in_q[$];
   axis_beat_t loop_q[$];
   axis_beat_t exp_hdr_q[$];
   axis_beat_t exp_out_q[$];
   pkt_tag_t   next_tag = '0;
   int         errors = 0;
   int         checks = 0;
   int         tests = 0;
   bit         timed_out = 1'b0;

   split_join_top dut_i (.*);

   bind split_join_top split_join_properties props_i (
      .axi4s_in         (axi4s_in),
      .rst              (rst),
      .sop_mismatch_clr (sop_mismatch_clr),
      .sop_mismatch     (sop_mismatch),
      .hdr_out_beat     (hdr_out_beat),
      .hdr_out_valid    (hdr_out_valid),
      .hdr_out_ready    (hdr_out_ready),
      .pkt_out_beat     (pkt_out_beat),
      .pkt_out_valid    (pkt_out_valid),
      .pkt_out_ready    (pkt_out_ready)
   );

   initial begin
      axi4s_in = 1'b0;
      forever #50 axi4s_in = ~axi4s_in;
   end

   // ----------------------------
   // compare tasks
   // ----------------------------

   // fields print as data/keep/tag/last.
   task automatic check_beat(input string what, input axis_beat_t got, input axis_beat_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s got %h/%h/%h/%b, expected %h/%h/%h/%b",
                  $time, what, got.data, got.keep, got.tag, got.last,
                  exp.data, exp.keep, exp.tag, exp.last);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s sop_mismatch is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // ----------------------------
   // stimulus and reference model
   // ----------------------------

   // one packet of at least h+1 beats, with its expected header and joined beats.
   task automatic build_packet(input hdr_len_t h, input bit corrupt);
      int         len;
      axis_beat_t b;
      axis_beat_t r;
      len = int'(h) + 1 + int'($urandom % (MAX_LEN - int'(h)));
      for (int i = 0; i < len; i++) begin
         b.data = {$urandom, $urandom};
         b.keep = axis_keep_t'($urandom);
         b.tag  = next_tag;
         b.last = (i == len - 1);
         in_q.push_back(b);
         // the processed header has its data inverted and maybe a bad tag.
         r      = b;
         r.data = ~b.data;
         if (corrupt) begin
            r.tag = ~b.tag;
         end
         if (h == '0) begin
            exp_hdr_q.push_back(b);
            exp_out_q.push_back(r);
         end else if (i < int'(h)) begin
            b.last = (i == int'(h) - 1);
            exp_hdr_q.push_back(b);
            r.last = 1'b0;
            exp_out_q.push_back(r);
         end else begin
            exp_out_q.push_back(b);
         end
      end
      next_tag++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge axi4s_in);
   endtask

   // sends n packets, loops the headers back and checks both outgoing streams.
   // header packet number corrupt returns with an inverted tag, -1 for none.
   task automatic run_traffic(input string name, input hdr_len_t h, input int n_pkts,
                              input bit bp, input int corrupt);
      int         cycles;
      int         err_start;
      int         hdr_idx;
      int         pkts_out;
      bit         in_fired;
      bit         ret_fired;
      axis_beat_t r;
      if (timed_out) begin
         return;
      end
      err_start = errors;
      hdr_idx   = 0;
      pkts_out  = 0;
      cycles    = 0;
      in_fired  = 1'b0;
      ret_fired = 1'b0;
      // the length is registered in the splitter, so let it settle first.
      hdr_length = h;
      idle_cycles(4);
      for (int p = 0; p < n_pkts; p++) begin
         build_packet(h, p == corrupt);
      end
      while ((in_q.size() + loop_q.size() + exp_hdr_q.size() + exp_out_q.size()) != 0
             && cycles < CYCLE_LIMIT) begin
         @(negedge axi4s_in);
         cycles++;
         // a valid beat is held until it transfers.
         if (!(pkt_in_valid && !in_fired)) begin
            pkt_in_valid = (in_q.size() != 0) && (!bp || ($urandom % 4 != 0));
            if (pkt_in_valid) begin
               pkt_in_beat = in_q[0];
            end
         end
         if (!(hdr_in_valid && !ret_fired)) begin
            hdr_in_valid = (loop_q.size() != 0) && (!bp || ($urandom % 4 != 0));
            if (hdr_in_valid) begin
               hdr_in_beat = loop_q[0];
            end
         end
         hdr_out_ready = bp ? logic'($urandom % 2) : 1'b1;
         pkt_out_ready = bp ? logic'($urandom % 2) : 1'b1;
         // everything is settled here and holds until the next rising edge.
         #1;
         in_fired  = pkt_in_valid && pkt_in_ready;
         ret_fired = hdr_in_valid && hdr_in_ready;
         if (in_fired) begin
            void'(in_q.pop_front());
         end
         if (ret_fired) begin
            void'(loop_q.pop_front());
         end
         if (hdr_out_valid && hdr_out_ready) begin
            if (exp_hdr_q.size() == 0) begin
               errors++;
               $display("Error at %0t: unexpected beat on hdr_out", $time);
            end else begin
               check_beat("hdr_out", hdr_out_beat, exp_hdr_q.pop_front());
            end
            r      = hdr_out_beat;
            r.data = ~r.data;
            if (hdr_idx == corrupt) begin
               r.tag = ~r.tag;
            end
            loop_q.push_back(r);
            if (hdr_out_beat.last) begin
               hdr_idx++;
            end
         end
         if (pkt_out_valid && pkt_out_ready) begin
            if (exp_out_q.size() == 0) begin
               errors++;
               $display("Error at %0t: unexpected beat on pkt_out", $time);
            end else begin
               check_beat("pkt_out", pkt_out_beat, exp_out_q.pop_front());
            end
            if (pkt_out_beat.last) begin
               pkts_out++;
            end
         end
      end
      if (cycles >= CYCLE_LIMIT) begin
         timed_out = 1'b1;
         $display("timeout: test %s stalled with %0d output beats still missing",
                  name, exp_out_q.size());
      end
      // the last transfers happen on the edge before this one.
      @(negedge axi4s_in);
      pkt_in_valid = 1'b0;
      hdr_in_valid = 1'b0;
      tests++;
      $display("test %s: %0d of %0d packets out, %0d errors",
               name, pkts_out, n_pkts, errors - err_start);
   endtask

   task automatic pulse_clear();
      @(negedge axi4s_in);
      sop_mismatch_clr = 1'b1;
      @(negedge axi4s_in);
      sop_mismatch_clr = 1'b0;
   endtask

   // ----------------------------
   // test sequence
   // ----------------------------

   initial begin
      void'($urandom(SEED));
      rst              = 1'b1;
      hdr_length       = 8'd2;
      sop_mismatch_clr = 1'b0;
      pkt_in_beat      = '0;
      pkt_in_valid     = 1'b0;
      hdr_out_ready    = 1'b0;
      hdr_in_beat      = '0;
      hdr_in_valid     = 1'b0;
      pkt_out_ready    = 1'b0;
      repeat (16) @(negedge axi4s_in);
      rst = 1'b0;

      run_traffic("split", 8'd2, 8, 1'b0, -1);
      check_flag("after split", sop_mismatch, 1'b0);
      run_traffic("round_trip", 8'd3, 10, 1'b0, -1);
      run_traffic("bypass", 8'd0, 8, 1'b0, -1);
      check_flag("after bypass", sop_mismatch, 1'b0);
      // packet 1 is corrupted and the packets after it are good.
      run_traffic("mismatch", 8'd2, 5, 1'b0, 1);
      check_flag("after mismatch", sop_mismatch, 1'b1);
      pulse_clear();
      check_flag("after clear", sop_mismatch, 1'b0);
      run_traffic("after_clear", 8'd2, 3, 1'b0, -1);
      check_flag("after clean run", sop_mismatch, 1'b0);
      run_traffic("back_pressure", 8'd3, 30, 1'b1, -1);

      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests, checks, errors, dut_i.props_i.fail_count);
      if (errors == 0 && !timed_out && dut_i.props_i.fail_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule : split_join_tb

// File: verification/split_join_properties.sv
// ----------------------------
// split/join stream properties.
// stall stability on the outgoing streams
// and the sticky flag reset and clear.
// ----------------------------

`timescale 1ns/1ps

module split_join_properties
   import axis_pkg::*;
(
   input  logic       axi4s_in,
   input  logic       rst,
   input  logic       sop_mismatch_clr,
   input  logic       sop_mismatch,
   input  axis_beat_t hdr_out_beat,
   input  logic       hdr_out_valid,
   input  logic       hdr_out_ready,
   input  axis_beat_t pkt_out_beat,
   input  logic       pkt_out_valid,
   input  logic       pkt_out_ready
);

   // number of assertion failures so far.
   int fail_count = 0;

   // a stalled sender holds its beat and valid until the transfer.
   hdr_out_hold: assert property (@(posedge axi4s_in) disable iff (rst)
      hdr_out_valid && !hdr_out_ready |=> hdr_out_valid && $stable(hdr_out_beat))
      else begin
         fail_count++;
         $error("hdr_out changed while stalled");
      end

   pkt_out_hold: assert property (@(posedge axi4s_in) disable iff (rst)
      pkt_out_valid && !pkt_out_ready |=> pkt_out_valid && $stable(pkt_out_beat))
      else begin
         fail_count++;
         $error("pkt_out changed while stalled");
      end

   // the flag comes out of reset low.
   flag_reset: assert property (@(posedge axi4s_in) rst |=> !sop_mismatch)
      else begin
         fail_count++;
         $error("sop_mismatch high after reset");
      end

   // the clear strobe wins over any mismatch in the same cycle.
   flag_clear: assert property (@(posedge axi4s_in) disable iff (rst)
      sop_mismatch_clr |=> !sop_mismatch)
      else begin
         fail_count++;
         $error("sop_mismatch still high after the clear strobe");
      end

endmodule : split_join_properties

// File: src/split_join_top.sv
// ----------------------------
// split/join top level.
// splitter, payload FIFO and joiner
// wired into one header processing loop.
// ----------------------------

`timescale 1ns/1ps

module split_join_top
   import axis_pkg::*;
   import split_join_pkg::*;
(
   input  logic       axi4s_in,
   input  logic       rst,
   input  hdr_len_t   hdr_length,
   input  logic       sop_mismatch_clr,

   // incoming packets.
   input  axis_beat_t pkt_in_beat,
   input  logic       pkt_in_valid,
   output logic       pkt_in_ready,

   // headers toward the outside processing.
   output axis_beat_t hdr_out_beat,
   output logic       hdr_out_valid,
   input  logic       hdr_out_ready,

   // processed headers coming back.
   input  axis_beat_t hdr_in_beat,
   input  logic       hdr_in_valid,
   output logic       hdr_in_ready,

   // rejoined packets.
   output axis_beat_t pkt_out_beat,
   output logic       pkt_out_valid,
   input  logic       pkt_out_ready,

   output logic       sop_mismatch
);

   // ----------------------------
   // internal streams
   // ----------------------------

   axis_beat_t split_pyld_beat;
   logic       split_pyld_valid;
   logic       split_pyld_ready;

   axis_beat_t fifo_pyld_beat;
   logic       fifo_pyld_valid;
   logic       fifo_pyld_ready;

   // the registered bypass bit also holds the FIFO flushed.
   logic       bypass;

   hdr_splitter splitter_i (
      .axi4s_in       (axi4s_in),
      .rst            (rst),
      .hdr_length     (hdr_length),
      .pkt_in_beat    (pkt_in_beat),
      .pkt_in_valid   (pkt_in_valid),
      .pkt_in_ready   (pkt_in_ready),
      .hdr_out_beat   (hdr_out_beat),
      .hdr_out_valid  (hdr_out_valid),
      .hdr_out_ready  (hdr_out_ready),
      .pyld_out_beat  (split_pyld_beat),
      .pyld_out_valid (split_pyld_valid),
      .pyld_out_ready (split_pyld_ready),
      .bypass         (bypass)
   );

   pyld_fifo pyld_fifo_i (
      .axi4s_in (axi4s_in),
      .rst      (rst),
      .flush    (bypass),
      .wr_beat  (split_pyld_beat),
      .wr_valid (split_pyld_valid),
      .wr_ready (split_pyld_ready),
      .rd_beat  (fifo_pyld_beat),
      .rd_valid (fifo_pyld_valid),
      .rd_ready (fifo_pyld_ready)
   );

   hdr_joiner joiner_i (
      .axi4s_in         (axi4s_in),
      .rst              (rst),
      .bypass           (bypass),
      .sop_mismatch_clr (sop_mismatch_clr),
      .hdr_in_beat      (hdr_in_beat),
      .hdr_in_valid     (hdr_in_valid),
      .hdr_in_ready     (hdr_in_ready),
      .pyld_in_beat     (fifo_pyld_beat),
      .pyld_in_valid    (fifo_pyld_valid),
      .pyld_in_ready    (fifo_pyld_ready),
      .pkt_out_beat     (pkt_out_beat),
      .pkt_out_valid    (pkt_out_valid),
      .pkt_out_ready    (pkt_out_ready),
      .sop_mismatch     (sop_mismatch)
   );

endmodule : split_join_top

// File: src/hdr_joiner.sv
// ----------------------------
// header joiner.
// rejoins each returned header with the
// next payload packet, passes returned
// packets through in bypass and keeps a
// sticky tag mismatch flag.
// ----------------------------

`timescale 1ns/1ps

module hdr_joiner
   import axis_pkg::*;
   import split_join_pkg::*;
(
   input  logic       axi4s_in,
   input  logic       rst,
   input  logic       bypass,
   input  logic       sop_mismatch_clr,

   input  axis_beat_t hdr_in_beat,
   input  logic       hdr_in_valid,
   output logic       hdr_in_ready,

   input  axis_beat_t pyld_in_beat,
   input  logic       pyld_in_valid,
   output logic       pyld_in_ready,

   output axis_beat_t pkt_out_beat,
   output logic       pkt_out_valid,
   input  logic       pkt_out_ready,

   output logic       sop_mismatch
);

   // ----------------------------
   // declarations
   // ----------------------------

   join_state_t state_q;
   pkt_tag_t    tag_q;
   logic        pyld_first_q;
   logic        byp_busy_q;
   logic        mismatch_q;
   axis_beat_t  out_beat_q;
   logic        out_valid_q;
   logic        out_free;
   logic        hdr_fire;
   logic        pyld_fire;
   axis_beat_t  load_beat;
   logic        mismatch_evt;

   // ----------------------------
   // input selection
   // ----------------------------

   // the output register accepts a beat when empty or drained this cycle.
   assign out_free = !out_valid_q || pkt_out_ready;

   // only the input that the state selects sees ready.
   always_comb begin
      hdr_in_ready  = 1'b0;
      pyld_in_ready = 1'b0;
      load_beat     = hdr_in_beat;
      case (state_q)
         JOIN_HDR: begin
            hdr_in_ready   = out_free;
            // the payload carries the packet end, not the header.
            load_beat.last = 1'b0;
         end
         JOIN_PYLD: begin
            pyld_in_ready = out_free;
            load_beat     = pyld_in_beat;
         end
         JOIN_BYPASS: begin
            hdr_in_ready = out_free;
         end
         default: begin
         end
      endcase
   end

   assign hdr_fire  = hdr_in_valid && hdr_in_ready;
   assign pyld_fire = pyld_in_valid && pyld_in_ready;

   // only the first payload beat is checked against the captured header tag.
   assign mismatch_evt = pyld_fire && pyld_first_q && (pyld_in_beat.tag != tag_q);

   // ----------------------------
   // state machine
   // ----------------------------

   always_ff @(posedge axi4s_in) begin
      if (rst) begin
         state_q      <= JOIN_IDLE;
         pyld_first_q <= 1'b0;
         byp_busy_q   <= 1'b0;
      end else begin
         case (state_q)
            JOIN_IDLE: begin
               if (bypass) begin
                  state_q <= JOIN_BYPASS;
               end else if (hdr_in_valid) begin
                  state_q <= JOIN_HDR;
               end
            end
            JOIN_HDR: begin
               if (hdr_fire && hdr_in_beat.last) begin
                  state_q      <= JOIN_PYLD;
                  pyld_first_q <= 1'b1;
               end
            end
            JOIN_PYLD: begin
               if (pyld_fire) begin
                  pyld_first_q <= 1'b0;
                  if (pyld_in_beat.last) begin
                     state_q <= JOIN_IDLE;
                  end
               end
            end
            JOIN_BYPASS: begin
               // leave bypass only on a packet boundary.
               if (hdr_fire) begin
                  byp_busy_q <= !hdr_in_beat.last;
                  if (hdr_in_beat.last && !bypass) begin
                     state_q <= JOIN_IDLE;
                  end
               end else if (!bypass && !byp_busy_q) begin
                  state_q <= JOIN_IDLE;
               end
            end
            default: begin
               state_q <= JOIN_IDLE;
            end
         endcase
      end
   end

   // the header tag is captured while the first header beat waits in JOIN_IDLE.
   always_ff @(posedge axi4s_in) begin
      if (state_q == JOIN_IDLE && hdr_in_valid) begin
         tag_q <= hdr_in_beat.tag;
      end
   end

   // ----------------------------
   // output stage and flag
   // ----------------------------

   always_ff @(posedge axi4s_in) begin
      if (hdr_fire || pyld_fire) begin
         out_beat_q <= load_beat;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (rst) begin
         out_valid_q <= 1'b0;
         mismatch_q  <= 1'b0;
      end else begin
         if (hdr_fire || pyld_fire) begin
            out_valid_q <= 1'b1;
         end else if (pkt_out_ready) begin
            out_valid_q <= 1'b0;
         end
         // the clear strobe wins over a mismatch in the same cycle.
         if (sop_mismatch_clr) begin
            mismatch_q <= 1'b0;
         end else if (mismatch_evt) begin
            mismatch_q <= 1'b1;
         end
      end
   end

   assign pkt_out_beat  = out_beat_q;
   assign pkt_out_valid = out_valid_q;
   assign sop_mismatch  = mismatch_q;

endmodule : hdr_joiner

// File: src/pyld_fifo.sv
// ----------------------------
// payload FIFO.
// circular beat buffer between the
// splitter and the joiner, with a
// registered read port and a flush.
// ----------------------------

`timescale 1ns/1ps

module pyld_fifo
   import axis_pkg::*;
   import split_join_pkg::*;
(
   input  logic       axi4s_in,
   input  logic       rst,
   input  logic       flush,

   input  axis_beat_t wr_beat,
   input  logic       wr_valid,
   output logic       wr_ready,

   output axis_beat_t rd_beat,
   output logic       rd_valid,
   input  logic       rd_ready
);

   // ----------------------------
   // declarations
   // ----------------------------

   axis_beat_t            mem [PYLD_FIFO_DEPTH];
   logic [PYLD_PTR_W-1:0] wr_ptr_q;
   logic [PYLD_PTR_W-1:0] rd_ptr_q;
   logic [PYLD_PTR_W:0]   count_q;
   axis_beat_t            rd_beat_q;
   logic                  rd_valid_q;
   logic                  out_free;
   logic                  mem_empty;
   logic                  wr_fire;
   logic                  wr_direct;
   logic                  push_mem;
   logic                  pop_mem;

   // ----------------------------
   // handshake decode
   // ----------------------------

   // count_q tracks the memory only, not the beat in the read register.
   assign mem_empty = (count_q == '0);
   assign wr_ready  = (count_q != PYLD_FIFO_DEPTH);
   assign wr_fire   = wr_valid && wr_ready;

   // the read register can take a beat when empty or when it is consumed now.
   assign out_free = !rd_valid_q || rd_ready;
   assign pop_mem  = out_free && !mem_empty;

   // with nothing stored, a written beat goes straight to the read register.
   // this makes it readable in the next cycle.
   assign wr_direct = wr_fire && out_free && mem_empty;
   assign push_mem  = wr_fire && !wr_direct;

   // ----------------------------
   // storage
   // ----------------------------

   always_ff @(posedge axi4s_in) begin
      if (push_mem) begin
         mem[wr_ptr_q] <= wr_beat;
      end
      if (pop_mem) begin
         rd_beat_q <= mem[rd_ptr_q];
      end else if (wr_direct) begin
         rd_beat_q <= wr_beat;
      end
   end

   // ----------------------------
   // pointers and occupancy
   // ----------------------------

   always_ff @(posedge axi4s_in) begin
      if (rst || flush) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         // the pointers wrap naturally at the power-of-two depth.
         if (push_mem) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_mem) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // a push and a pop together leave the count unchanged.
         if (push_mem && !pop_mem) begin
            count_q <= count_q + 1'b1;
         end else if (pop_mem && !push_mem) begin
            count_q <= count_q - 1'b1;
         end
         if (pop_mem || wr_direct) begin
            rd_valid_q <= 1'b1;
         end else if (rd_ready) begin
            rd_valid_q <= 1'b0;
         end
      end
   end

   assign rd_beat  = rd_beat_q;
   assign rd_valid = rd_valid_q;

endmodule : pyld_fifo

// File: src/hdr_splitter.sv
// ----------------------------
// header splitter.
// sends the first hdr_length beats of each
// packet to the header port and the rest
// to the payload port, or the whole packet
// to the header port when bypassed.
// ----------------------------

`timescale 1ns/1ps

module hdr_splitter
   import axis_pkg::*;
   import split_join_pkg::*;
(
   input  logic       axi4s_in,
   input  logic       rst,
   input  hdr_len_t   hdr_length,

   input  axis_beat_t pkt_in_beat,
   input  logic       pkt_in_valid,
   output logic       pkt_in_ready,

   output axis_beat_t hdr_out_beat,
   output logic       hdr_out_valid,
   input  logic       hdr_out_ready,

   output axis_beat_t pyld_out_beat,
   output logic       pyld_out_valid,
   input  logic       pyld_out_ready,

   output logic       bypass
);

   // ----------------------------
   // declarations
   // ----------------------------

   hdr_len_t   hdr_len_q;
   logic       bypass_q;
   hdr_len_t   beat_cnt_q;
   axis_beat_t out_beat_q;
   logic       out_valid_q;
   logic       out_to_hdr_q;
   logic       out_ready;
   logic       in_fire;
   logic       is_hdr;
   logic       hdr_last;

   // ----------------------------
   // routing decision
   // ----------------------------

   // the single output register drains into whichever port it is aimed at.
   assign out_ready = out_to_hdr_q ? hdr_out_ready : pyld_out_ready;

   // accept a new beat when the register is empty or is emptied this cycle.
   assign pkt_in_ready = !out_valid_q || out_ready;
   assign in_fire      = pkt_in_valid && pkt_in_ready;

   // beats below the registered length belong to the header.
   // in bypass every beat is a header beat.
   assign is_hdr = bypass_q || (beat_cnt_q < hdr_len_q);

   // the final header beat gets a last flag of its own.
   assign hdr_last = (beat_cnt_q == hdr_len_t'(hdr_len_q - 8'd1));

   // ----------------------------
   // control state
   // ----------------------------

   always_ff @(posedge axi4s_in) begin
      if (rst) begin
         hdr_len_q    <= '0;
         bypass_q     <= 1'b1;
         beat_cnt_q   <= '0;
         out_valid_q  <= 1'b0;
         out_to_hdr_q <= 1'b0;
      end else begin
         // hdr_length only moves between packets, so sampling it every cycle is safe.
         hdr_len_q <= hdr_length;
         bypass_q  <= (hdr_length == '0);

         if (in_fire) begin
            out_valid_q  <= 1'b1;
            out_to_hdr_q <= is_hdr;
            // the counter restarts at each packet end and stops at hdr_len_q.
            if (pkt_in_beat.last) begin
               beat_cnt_q <= '0;
            end else if (!bypass_q && is_hdr) begin
               beat_cnt_q <= beat_cnt_q + 8'd1;
            end
         end else if (out_ready) begin
            out_valid_q <= 1'b0;
         end
      end
   end

   // the beat itself is held without reset.
   always_ff @(posedge axi4s_in) begin
      if (in_fire) begin
         out_beat_q <= pkt_in_beat;
         // a split header ends on its own last beat.
         if (!bypass_q && is_hdr) begin
            out_beat_q.last <= hdr_last;
         end
      end
   end

   // ----------------------------
   // outputs
   // ----------------------------

   assign hdr_out_beat   = out_beat_q;
   assign hdr_out_valid  = out_valid_q && out_to_hdr_q;
   assign pyld_out_beat  = out_beat_q;
   assign pyld_out_valid = out_valid_q && !out_to_hdr_q;

   // the joiner and the payload FIFO follow this registered bit.
   assign bypass = bypass_q;

endmodule : hdr_splitter

// File: src/axis_pkg.sv
// ----------------------------
// stream beat definitions.
// width constants and the packed beat
// carried by every stream port.
// ----------------------------

package axis_pkg;

   // the tag type lives with the packet level definitions.
   import split_join_pkg::*;

   // ----------------------------
   // stream widths
   // ----------------------------

   // bytes per beat on every stream in the subsystem.
   localparam int AXIS_DATA_BYTES = 8;

   // data width follows from the byte count.
   localparam int AXIS_DATA_W = AXIS_DATA_BYTES * 8;

   // ----------------------------
   // beat fields
   // ----------------------------

   // beat payload data.
   typedef logic [AXIS_DATA_W-1:0] axis_data_t;

   // one byte-enable bit per data byte.
   typedef logic [AXIS_DATA_BYTES-1:0] axis_keep_t;

   // ----------------------------
   // beat struct
   // ----------------------------

   // one beat of a packet stream.
   // the struct is 81 bits wide, with data in the top bits and last in bit 0.
   // valid and ready travel beside it as separate single-bit signals.
   typedef struct packed {
      axis_data_t data;
      axis_keep_t keep;
      pkt_tag_t   tag;
      logic       last;
   } axis_beat_t;

endpackage : axis_pkg

// File: src/split_join_pkg.sv
// ----------------------------
// split/join shared types.
// header length, packet tag, joiner
// states and payload FIFO sizing.
// ----------------------------

package split_join_pkg;

   // ----------------------------
   // packet level types
   // ----------------------------

   // the header length is counted in whole 64-bit beats, not bytes.
   typedef logic [7:0] hdr_len_t;

   // each packet carries a tag that must survive the header processing path.
   typedef logic [7:0] pkt_tag_t;

   // ----------------------------
   // joiner state machine
   // ----------------------------

   // JOIN_IDLE waits for a header, JOIN_HDR forwards header beats,
   // JOIN_PYLD forwards one payload packet and JOIN_BYPASS passes
   // returned packets straight through.
   typedef enum logic [1:0] {
      JOIN_IDLE   = 2'd0,
      JOIN_HDR    = 2'd1,
      JOIN_PYLD   = 2'd2,
      JOIN_BYPASS = 2'd3
   } join_state_t;

   // ----------------------------
   // payload FIFO sizing
   // ----------------------------

   // the depth is a power of two so the pointers wrap on their own.
   localparam int PYLD_FIFO_DEPTH = 64;
   localparam int PYLD_PTR_W      = 6;

endpackage : split_join_pkg
